//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= cpu_core_tb
FILELIST  ?= cpu_core.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := No errors

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- common/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

  ////////////////////////////////////////////////////////////
  // Widths shared by every stage
  ////////////////////////////////////////////////////////////
  localparam int data_width     = 16;  // Machine word and register width
  localparam int reg_addr_width = 4;   // Sixteen architectural registers
  localparam int imm_width      = 4;   // Immediate lives in the low nibble
  localparam int shamt_width    = 4;   // Shift amount taken from the operand low bits

  // Instruction layout, most significant nibble first
  // [15:12] opcode, [11:8] rd, [7:4] rs, [3:0] rt or signed immediate
  // Shifts take their amount from the immediate nibble
  // A store reads its data register from the rd nibble
  typedef enum logic [3:0] {
    op_add  = 4'h0,  // rd = rs + rt
    op_sub  = 4'h1,  // rd = rs - rt
    op_xor  = 4'h2,  // rd = rs ^ rt
    op_and  = 4'h3,  // rd = rs & rt
    op_sll  = 4'h4,  // rd = rs << imm
    op_sra  = 4'h5,  // rd = rs >>> imm, sign filled
    op_addi = 4'h6,  // rd = rs + sext(imm)
    op_sw   = 4'h9,  // mem[rs + sext(imm)] = rd
    op_pcs  = 4'he,  // rd = next PC
    op_hlt  = 4'hf   // Stop retiring instructions until reset
  } opcode_t;

  // Operations the execute stage knows how to perform
  typedef enum logic [2:0] {
    alu_add = 3'd0,
    alu_sub = 3'd1,
    alu_and = 3'd2,
    alu_xor = 3'd3,
    alu_sll = 3'd4,
    alu_sra = 3'd5
  } alu_op_t;

  ////////////////////////////////////////////////////////////
  // Control bundles carried across the ID/EX boundary
  ////////////////////////////////////////////////////////////
  typedef struct packed {
    logic [reg_addr_width-1:0] src_reg1;       // First source register number
    logic [reg_addr_width-1:0] src_reg2;       // Second source register number
    logic [data_width-1:0]     alu_in1;        // First ALU operand
    logic [data_width-1:0]     alu_imm;        // Sign extended immediate
    logic [data_width-1:0]     src_reg2_data;  // Second register operand
    alu_op_t                   alu_op;         // Operation to run
    logic                      alu_src;        // Use the immediate as second operand
    logic                      z_en;           // Update the zero flag
    logic                      nv_en;          // Update the sign and overflow flags
  } ex_signals_t;

  typedef struct packed {
    logic [data_width-1:0] mem_write_data;  // Store data
    logic                  mem_enable;      // Issue a memory access
    logic                  mem_write;       // The access is a write
  } mem_signals_t;

  typedef struct packed {
    logic [reg_addr_width-1:0] reg_rd;     // Destination register
    logic                      reg_write;  // Write the result back
    logic                      hlt;        // Halt instruction
    logic                      pcs;        // Result is the saved next PC
  } wb_signals_t;

  // Result handed back to the register file one cycle after decode
  typedef struct packed {
    logic                      valid;
    logic [reg_addr_width-1:0] reg_rd;
    logic [data_width-1:0]     data;
  } wb_result_t;

  // Request presented on the top level memory port
  typedef struct packed {
    logic                  enable;
    logic                  write;
    logic [data_width-1:0] addr;
    logic [data_width-1:0] data;
  } mem_req_t;

endpackage

`default_nettype wire

//--- cpu_core.f
common/cpu_pkg.sv
decode/instr_decode.sv
decode/reg_file.sv
source/id_ex_pipe_reg.sv
execute/alu_execute.sv
source/cpu_core.sv
testbench/cpu_core_properties.sv
testbench/cpu_core_tb.sv

//--- decode/instr_decode.sv
`timescale 1ns/100ps
`default_nettype none

module instr_decode (
  input  wire logic                                 instr_valid,  // Fetch strobe
  input  wire logic [cpu_pkg::data_width-1:0]       instr,        // Instruction word
  input  wire logic [cpu_pkg::data_width-1:0]       pc_next,      // Address after this one
  output logic      [cpu_pkg::reg_addr_width-1:0]   rs_addr,      // Register file read port 1
  output logic      [cpu_pkg::reg_addr_width-1:0]   rt_addr,      // Register file read port 2
  input  wire logic [cpu_pkg::data_width-1:0]       rs_data,      // Read data for rs
  input  wire logic [cpu_pkg::data_width-1:0]       rt_data,      // Read data for rt
  output cpu_pkg::ex_signals_t                      ex_signals,   // Execute bundle
  output cpu_pkg::mem_signals_t                     mem_signals,  // Memory bundle
  output cpu_pkg::wb_signals_t                      wb_signals    // Write-back bundle
);

  cpu_pkg::opcode_t                       opcode;  // Top nibble seen as an opcode
  logic [cpu_pkg::reg_addr_width-1:0]     rd_fld;  // Destination nibble
  logic [cpu_pkg::data_width-1:0]         imm_ext; // Sign extended low nibble

  ////////////////////////////////////////////////////////////
  // Field extraction
  ////////////////////////////////////////////////////////////
  assign opcode = cpu_pkg::opcode_t'(instr[15:12]);
  assign rd_fld = instr[11:8];
  assign imm_ext = {{(cpu_pkg::data_width-cpu_pkg::imm_width){instr[3]}},
                    instr[cpu_pkg::imm_width-1:0]};

  assign rs_addr = instr[7:4];  // Always the first operand

  // A store has no rt, its data comes from the rd register instead
  assign rt_addr = (opcode == cpu_pkg::op_sw) ? rd_fld : instr[3:0];

  ////////////////////////////////////////////////////////////
  // Control generation
  ////////////////////////////////////////////////////////////
  always_comb begin
    // Start from a bubble and switch on only what the opcode needs
    ex_signals  = '0;
    mem_signals = '0;
    wb_signals  = '0;

    ex_signals.src_reg1      = rs_addr;
    ex_signals.src_reg2      = rt_addr;
    ex_signals.alu_in1       = rs_data;
    ex_signals.alu_imm       = imm_ext;
    ex_signals.src_reg2_data = rt_data;
    ex_signals.alu_op        = cpu_pkg::alu_add;
    mem_signals.mem_write_data = rt_data;  // Only meaningful for a store
    wb_signals.reg_rd          = rd_fld;

    // Without a valid strobe every enable stays low
    if (instr_valid) begin
      case (opcode)
        cpu_pkg::op_add: begin
          ex_signals.alu_op = cpu_pkg::alu_add;
          ex_signals.z_en   = 1'b1;
          ex_signals.nv_en  = 1'b1;
          wb_signals.reg_write = 1'b1;
        end
        cpu_pkg::op_sub: begin
          ex_signals.alu_op = cpu_pkg::alu_sub;
          ex_signals.z_en   = 1'b1;
          ex_signals.nv_en  = 1'b1;
          wb_signals.reg_write = 1'b1;
        end
        cpu_pkg::op_and: begin
          ex_signals.alu_op = cpu_pkg::alu_and;
          ex_signals.z_en   = 1'b1;  // Logic ops touch Z only
          wb_signals.reg_write = 1'b1;
        end
        cpu_pkg::op_xor: begin
          ex_signals.alu_op = cpu_pkg::alu_xor;
          ex_signals.z_en   = 1'b1;
          wb_signals.reg_write = 1'b1;
        end
        cpu_pkg::op_sll: begin
          ex_signals.alu_op  = cpu_pkg::alu_sll;
          ex_signals.alu_src = 1'b1;  // Shift amount is the immediate
          ex_signals.z_en    = 1'b1;
          wb_signals.reg_write = 1'b1;
        end
        cpu_pkg::op_sra: begin
          ex_signals.alu_op  = cpu_pkg::alu_sra;
          ex_signals.alu_src = 1'b1;
          ex_signals.z_en    = 1'b1;
          wb_signals.reg_write = 1'b1;
        end
        cpu_pkg::op_addi: begin
          ex_signals.alu_src = 1'b1;
          ex_signals.z_en    = 1'b1;
          ex_signals.nv_en   = 1'b1;
          wb_signals.reg_write = 1'b1;
        end
        cpu_pkg::op_sw: begin
          ex_signals.alu_src     = 1'b1;  // Address is rs plus offset
          mem_signals.mem_enable = 1'b1;
          mem_signals.mem_write  = 1'b1;
        end
        cpu_pkg::op_pcs: begin
          // Next PC plus zero lands in rd through the adder
          ex_signals.alu_in1 = pc_next;
          ex_signals.alu_imm = '0;
          ex_signals.alu_src = 1'b1;
          wb_signals.reg_write = 1'b1;
          wb_signals.pcs       = 1'b1;
        end
        cpu_pkg::op_hlt: wb_signals.hlt = 1'b1;
        default: ;  // Unused codes retire as no-operations
      endcase
    end
  end

endmodule

`default_nettype wire

//--- decode/reg_file.sv
`timescale 1ns/100ps
`default_nettype none

module reg_file (
  input  wire logic                               clk,
  input  wire logic                               reset,      // Clears all registers
  input  wire logic [cpu_pkg::reg_addr_width-1:0] rs_addr,
  input  wire logic [cpu_pkg::reg_addr_width-1:0] rt_addr,
  output logic      [cpu_pkg::data_width-1:0]     rs_data,
  output logic      [cpu_pkg::data_width-1:0]     rt_data,
  input  wire cpu_pkg::wb_result_t                wb_result   // Write port from execute
);

  localparam int num_regs = 2 ** cpu_pkg::reg_addr_width;

  logic [cpu_pkg::data_width-1:0] regs [num_regs];  // Architectural registers
  logic                           wr_en;            // Write to a real register

  // Register 0 is hard wired so a write to it is simply dropped
  assign wr_en = wb_result.valid && (wb_result.reg_rd != '0);

  ////////////////////////////////////////////////////////////
  // Write port
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[wb_result.reg_rd] <= wb_result.data;
    end
  end

  ////////////////////////////////////////////////////////////
  // Read ports with write-through
  ////////////////////////////////////////////////////////////
  // The instruction in execute has not written yet, so its data goes straight across
  always_comb begin
    if (rs_addr == '0) rs_data = '0;                                    // Zero register
    else if (wr_en && (wb_result.reg_rd == rs_addr)) rs_data = wb_result.data;
    else rs_data = regs[rs_addr];

    if (rt_addr == '0) rt_data = '0;
    else if (wr_en && (wb_result.reg_rd == rt_addr)) rt_data = wb_result.data;
    else rt_data = regs[rt_addr];
  end

endmodule

`default_nettype wire

//--- execute/alu_execute.sv
`timescale 1ns/100ps
`default_nettype none

module alu_execute (
  input  wire logic                  clk,
  input  wire logic                  reset,
  input  wire cpu_pkg::ex_signals_t  id_ex_ex_signals,
  input  wire cpu_pkg::mem_signals_t id_ex_mem_signals,
  input  wire cpu_pkg::wb_signals_t  id_ex_wb_signals,
  output cpu_pkg::wb_result_t        wb_result,  // Goes back to the register file
  output cpu_pkg::mem_req_t          mem_req,    // Store request to the memory port
  output logic [2:0]                 flags,      // Z, N, V from high bit down
  output logic                       halted      // Sticky until reset
);

  logic [cpu_pkg::data_width-1:0]  op_a;        // First operand
  logic [cpu_pkg::data_width-1:0]  op_b;        // Second operand after select
  logic [cpu_pkg::data_width-1:0]  sum;         // op_a + op_b
  logic [cpu_pkg::data_width-1:0]  diff;        // op_a - op_b
  logic [cpu_pkg::data_width-1:0]  alu_result;
  logic [cpu_pkg::shamt_width-1:0] shamt;
  logic                            ovf;         // Signed overflow of add or sub
  logic                            msb_a, msb_b;

  ////////////////////////////////////////////////////////////
  // Operand select and arithmetic
  ////////////////////////////////////////////////////////////
  assign op_a  = id_ex_ex_signals.alu_in1;
  assign op_b  = id_ex_ex_signals.alu_src ? id_ex_ex_signals.alu_imm
                                          : id_ex_ex_signals.src_reg2_data;
  assign shamt = op_b[cpu_pkg::shamt_width-1:0];  // Low bits give the shift distance
  assign sum   = op_a + op_b;
  assign diff  = op_a - op_b;
  assign msb_a = op_a[cpu_pkg::data_width-1];
  assign msb_b = op_b[cpu_pkg::data_width-1];

  always_comb begin
    ovf = 1'b0;  // Logic ops never overflow
    case (id_ex_ex_signals.alu_op)
      cpu_pkg::alu_add: begin
        alu_result = sum;
        ovf = (msb_a == msb_b) && (sum[cpu_pkg::data_width-1] != msb_a);  // Like signs, flip
      end
      cpu_pkg::alu_sub: begin
        alu_result = diff;
        ovf = (msb_a != msb_b) && (diff[cpu_pkg::data_width-1] != msb_a);
      end
      cpu_pkg::alu_and: alu_result = op_a & op_b;
      cpu_pkg::alu_xor: alu_result = op_a ^ op_b;
      cpu_pkg::alu_sll: alu_result = op_a << shamt;
      cpu_pkg::alu_sra: alu_result = $signed(op_a) >>> shamt;  // Sign bit fills from the left
      default: alu_result = sum;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Results to the register file and memory port
  ////////////////////////////////////////////////////////////
  // Nothing leaves the stage once the core has stopped
  assign wb_result.valid  = id_ex_wb_signals.reg_write & ~halted;
  assign wb_result.reg_rd = id_ex_wb_signals.reg_rd;
  assign wb_result.data   = id_ex_wb_signals.pcs ? op_a : alu_result;  // PCS saves the next PC

  assign mem_req.enable = id_ex_mem_signals.mem_enable & ~halted;
  assign mem_req.write  = id_ex_mem_signals.mem_write & ~halted;
  assign mem_req.addr   = alu_result;                        // Base plus offset
  assign mem_req.data   = id_ex_mem_signals.mem_write_data;

  ////////////////////////////////////////////////////////////
  // Flag register and halt
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      flags <= 3'b000;
    end else if (!halted) begin
      if (id_ex_ex_signals.z_en) flags[2] <= (alu_result == '0);
      if (id_ex_ex_signals.nv_en) begin
        flags[1] <= alu_result[cpu_pkg::data_width-1];  // Result sign
        flags[0] <= ovf;
      end
    end
  end

  // Once set only reset brings the core back
  always_ff @(posedge clk) begin
    if (reset) halted <= 1'b0;
    else if (id_ex_wb_signals.hlt) halted <= 1'b1;
  end

endmodule

`default_nettype wire

//--- source/cpu_core.sv
`timescale 1ns/100ps
`default_nettype none

module cpu_core (
  input  wire logic                           clk,
  input  wire logic                           reset,
  input  wire logic                           flush,        // Squash the instruction in decode
  input  wire logic                           instr_valid,  // Fetch presents a word
  input  wire logic [cpu_pkg::data_width-1:0] instr,
  input  wire logic [cpu_pkg::data_width-1:0] pc_next,
  output cpu_pkg::wb_result_t                 wb_result,
  output cpu_pkg::mem_req_t                   mem_req,
  output logic [2:0]                          flags,
  output logic                                halted
);

  logic [cpu_pkg::reg_addr_width-1:0] rs_addr, rt_addr;  // Decode read addresses
  logic [cpu_pkg::data_width-1:0]     rs_data, rt_data;  // Register file read data

  cpu_pkg::ex_signals_t  ex_signals, id_ex_ex_signals;
  cpu_pkg::mem_signals_t mem_signals, id_ex_mem_signals;
  cpu_pkg::wb_signals_t  wb_signals, id_ex_wb_signals;

  ////////////////////////////////////////////////////////////
  // Decode stage
  ////////////////////////////////////////////////////////////
  instr_decode instr_decode0 (
    .instr_valid(instr_valid), .instr(instr), .pc_next(pc_next),
    .rs_addr(rs_addr), .rt_addr(rt_addr), .rs_data(rs_data), .rt_data(rt_data),
    .ex_signals(ex_signals), .mem_signals(mem_signals), .wb_signals(wb_signals)
  );

  // Written by execute, read by decode in the same cycle
  reg_file reg_file0 (
    .clk(clk), .reset(reset),
    .rs_addr(rs_addr), .rt_addr(rt_addr), .rs_data(rs_data), .rt_data(rt_data),
    .wb_result(wb_result)
  );

  ////////////////////////////////////////////////////////////
  // Stage boundary and execute
  ////////////////////////////////////////////////////////////
  // Execute takes the next PC from alu_in1, so the registered copy has no reader here
  id_ex_pipe_reg id_ex_pipe_reg0 (
    .clk(clk), .reset(reset), .flush(flush), .if_id_pc_next(pc_next),
    .ex_signals(ex_signals), .mem_signals(mem_signals), .wb_signals(wb_signals),
    .id_ex_pc_next(), .id_ex_ex_signals(id_ex_ex_signals),
    .id_ex_mem_signals(id_ex_mem_signals), .id_ex_wb_signals(id_ex_wb_signals)
  );

  // Results go back to the register file and out of the core
  alu_execute alu_execute0 (
    .clk(clk), .reset(reset),
    .id_ex_ex_signals(id_ex_ex_signals), .id_ex_mem_signals(id_ex_mem_signals),
    .id_ex_wb_signals(id_ex_wb_signals),
    .wb_result(wb_result), .mem_req(mem_req), .flags(flags), .halted(halted)
  );

endmodule

`default_nettype wire

//--- source/id_ex_pipe_reg.sv
`timescale 1ns/100ps
`default_nettype none

module id_ex_pipe_reg (
  input  wire logic                            clk,
  input  wire logic                            reset,          // Clears every field
  input  wire logic                            flush,          // Turns the stage into a bubble
  input  wire logic [cpu_pkg::data_width-1:0]  if_id_pc_next,  // Next PC from fetch
  input  wire cpu_pkg::ex_signals_t            ex_signals,
  input  wire cpu_pkg::mem_signals_t           mem_signals,
  input  wire cpu_pkg::wb_signals_t            wb_signals,
  output logic      [cpu_pkg::data_width-1:0]  id_ex_pc_next,
  output cpu_pkg::ex_signals_t                 id_ex_ex_signals,
  output cpu_pkg::mem_signals_t                id_ex_mem_signals,
  output cpu_pkg::wb_signals_t                 id_ex_wb_signals
);

  logic clr;  // Clear for the control bundles

  // Either reset or a flush kills the instruction in this stage
  assign clr = reset | flush;

  ////////////////////////////////////////////////////////////
  // Next PC
  ////////////////////////////////////////////////////////////
  // Only reset clears it, a flushed slot still carries its PC
  always_ff @(posedge clk) begin
    if (reset) id_ex_pc_next <= '0;
    else id_ex_pc_next <= if_id_pc_next;
  end

  ////////////////////////////////////////////////////////////
  // Control bundles
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (clr) begin
      id_ex_ex_signals  <= '0;  // All enables low means nothing retires
      id_ex_mem_signals <= '0;
      id_ex_wb_signals  <= '0;
    end else begin
      id_ex_ex_signals  <= ex_signals;
      id_ex_mem_signals <= mem_signals;
      id_ex_wb_signals  <= wb_signals;
    end
  end

endmodule

`default_nettype wire

//--- testbench/cpu_core_properties.sv
`timescale 1ns/100ps
`default_nettype none

module cpu_core_properties (
  input wire logic                clk,
  input wire logic                reset,
  input wire logic                flush,
  input wire cpu_pkg::wb_result_t wb_result,
  input wire cpu_pkg::mem_req_t   mem_req,
  input wire logic                halted
);

  int fail_count = 0;  // Failed assertions seen so far

  ////////////////////////////////////////////////////////////
  // Reset and flush leave execute empty
  ////////////////////////////////////////////////////////////
  reset_clears: assert property (@(posedge clk)
    reset |=> (!wb_result.valid && !mem_req.enable && !halted))
    else begin
      $error("Write, request or halt active in the cycle after reset");
      fail_count++;
    end

  // A flush sampled with an instruction turns it into a bubble
  flush_kills: assert property (@(posedge clk)
    (flush && !reset) |=> (!wb_result.valid && !mem_req.enable))
    else begin
      $error("Flushed instruction still wrote or requested memory");
      fail_count++;
    end

  // Halt is sticky until reset and blocks every side effect
  halt_sticky: assert property (@(posedge clk) (halted && !reset) |=> halted)
    else begin
      $error("Halted dropped without reset");
      fail_count++;
    end

  halt_blocks: assert property (@(posedge clk) halted |-> (!wb_result.valid && !mem_req.enable))
    else begin
      $error("Write or request issued while halted");
      fail_count++;
    end

endmodule

`default_nettype wire

//--- testbench/cpu_core_tb.sv
`timescale 1ns/100ps
`default_nettype none

module cpu_core_tb;

  logic                               clk;
  logic                               reset;
  logic                               flush;
  logic                               instr_valid;
  logic [cpu_pkg::data_width-1:0]     instr;
  logic [cpu_pkg::data_width-1:0]     pc_next;
  cpu_pkg::wb_result_t                wb_result;
  cpu_pkg::mem_req_t                  mem_req;
  logic [2:0]                         flags;   // Z, N, V
  logic                               halted;

  // Reference state updated in program order, which the bypass lets the DUT follow
  logic [15:0]         model_regs [16];
  logic [2:0]          model_flags;
  logic                model_halted;
  cpu_pkg::wb_result_t pend_wb;      // Expected outputs of the instruction now in execute
  cpu_pkg::mem_req_t   pend_mem;
  logic [2:0]          pend_flags;   // Flags lag one cycle behind the result
  logic                pend_halted;
  logic [31:0]         rng;
  logic [15:0]         pc;
  int                  checks;
  int                  errors;

  cpu_core dut0 (
    .clk(clk), .reset(reset), .flush(flush), .instr_valid(instr_valid), .instr(instr),
    .pc_next(pc_next), .wb_result(wb_result), .mem_req(mem_req), .flags(flags), .halted(halted)
  );

  bind cpu_core cpu_core_properties props0 (
    .clk(clk), .reset(reset), .flush(flush), .wb_result(wb_result), .mem_req(mem_req),
    .halted(halted)
  );

  always #10 clk = ~clk;  // 20 ns period

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////
  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [3:0] pick_reg(input logic [31:0] x);
    return 4'd1 + 4'(x[7:0] % 8'd6);  // Registers 1 to 6 hold the loaded operands
  endfunction

  function automatic logic [15:0] encode(input cpu_pkg::opcode_t op,
                                         input logic [3:0] rd, rs, rt);
    return {op, rd, rs, rt};
  endfunction

  task automatic check_eq(input string what, input logic [15:0] got, input logic [15:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("FAIL %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  // Compares the DUT with the instruction issued one step earlier
  task automatic check_pending();
    check_eq("wb_result.valid", 16'(wb_result.valid), 16'(pend_wb.valid));
    if (pend_wb.valid) begin
      check_eq("wb_result.reg_rd", 16'(wb_result.reg_rd), 16'(pend_wb.reg_rd));
      check_eq("wb_result.data", wb_result.data, pend_wb.data);
    end
    check_eq("mem_req.enable", 16'(mem_req.enable), 16'(pend_mem.enable));
    if (pend_mem.enable) begin
      check_eq("mem_req.write", 16'(mem_req.write), 16'(pend_mem.write));
      check_eq("mem_req.addr", mem_req.addr, pend_mem.addr);
      check_eq("mem_req.data", mem_req.data, pend_mem.data);
    end
    check_eq("flags", 16'(flags), 16'(pend_flags));
    check_eq("halted", 16'(halted), 16'(pend_halted));
  endtask

  // Runs the reference model for one instruction as it is issued
  task automatic compute_expect(input logic live, input logic [15:0] word, input logic [15:0] pcv);
    cpu_pkg::opcode_t op;
    logic [15:0] a, b, imm, res;
    logic [16:0] wide;  // One extra sign bit exposes signed overflow
    logic        z_upd, nv_upd;
    op = cpu_pkg::opcode_t'(word[15:12]);
    a = model_regs[word[7:4]];
    b = model_regs[word[3:0]];
    imm = {{12{word[3]}}, word[3:0]};
    res = '0;
    wide = '0;
    z_upd = 1'b0;
    nv_upd = 1'b0;
    pend_wb = '0;
    pend_mem = '0;
    pend_flags = model_flags;
    pend_halted = model_halted;
    if (live && !model_halted) begin
      case (op)
        cpu_pkg::op_add: begin
          wide = {a[15], a} + {b[15], b};
          res = wide[15:0];
          nv_upd = 1'b1;
        end
        cpu_pkg::op_sub: begin
          wide = {a[15], a} - {b[15], b};
          res = wide[15:0];
          nv_upd = 1'b1;
        end
        cpu_pkg::op_addi: begin
          wide = {a[15], a} + {imm[15], imm};
          res = wide[15:0];
          nv_upd = 1'b1;
        end
        cpu_pkg::op_and:  res = a & b;
        cpu_pkg::op_xor:  res = a ^ b;
        cpu_pkg::op_sll:  res = a << word[3:0];
        cpu_pkg::op_sra:  res = $signed(a) >>> word[3:0];  // Sign fills the top
        cpu_pkg::op_pcs:  res = pcv;
        cpu_pkg::op_sw: begin
          pend_mem = '{enable: 1'b1, write: 1'b1, addr: a + imm, data: model_regs[word[11:8]]};
        end
        cpu_pkg::op_hlt: model_halted = 1'b1;
        default: ;
      endcase
      z_upd = (op inside {cpu_pkg::op_add, cpu_pkg::op_sub, cpu_pkg::op_and, cpu_pkg::op_xor,
                          cpu_pkg::op_sll, cpu_pkg::op_sra, cpu_pkg::op_addi});
      if (z_upd || op == cpu_pkg::op_pcs) begin
        pend_wb = '{valid: 1'b1, reg_rd: word[11:8], data: res};
        if (word[11:8] != 4'd0) model_regs[word[11:8]] = res;  // Register 0 stays zero
      end
      if (z_upd) model_flags[2] = (res == '0);
      if (nv_upd) model_flags[1:0] = {res[15], wide[16] ^ wide[15]};
    end
  endtask

  // One cycle drives on the rising edge and checks and predicts at the falling edge
  task automatic step(input logic valid, input logic kill, input logic [15:0] word);
    @(posedge clk);
    instr_valid <= valid;
    flush <= kill;
    instr <= word;
    pc_next <= pc;
    @(negedge clk);
    check_pending();
    compute_expect(valid && !kill, word, pc);
    pc = pc + 16'd2;
  endtask

  task automatic issue(input logic [15:0] word);
    step(1'b1, 1'b0, word);
  endtask

  task automatic drain();
    step(1'b0, 1'b0, '0);
    step(1'b0, 1'b0, '0);  // Second bubble lets the last flag update be seen
  endtask

  task automatic apply_reset();
    @(posedge clk);
    reset <= 1'b1;
    instr_valid <= 1'b0;
    flush <= 1'b0;
    repeat (3) @(posedge clk);
    reset <= 1'b0;
    for (int i = 0; i < 16; i++) model_regs[i] = '0;
    model_flags = '0;
    model_halted = 1'b0;
    pend_wb = '0;
    pend_mem = '0;
    pend_flags = '0;
    pend_halted = 1'b0;
  endtask

  task automatic report_test(input string name, input int start_errs);
    $display("test %s finished, %0d failures", name, errors - start_errs);
  endtask

  ////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////
  task automatic test_alu_ops();
    int          start_errs;
    logic [3:0]  ra, rb;
    start_errs = errors;
    for (int r = 1; r <= 6; r++) begin
      rng = xorshift(rng);
      issue(encode(cpu_pkg::op_addi, 4'(r), 4'd0, rng[3:0]));
      issue(encode(cpu_pkg::op_sll, 4'(r), 4'(r), rng[7:4]));  // Spreads the bits via the bypass
    end
    for (int round = 0; round < 4; round++) begin
      rng = xorshift(rng);
      ra = pick_reg(rng);
      rb = pick_reg(rng >> 8);
      issue(encode(cpu_pkg::op_add, 4'd7, ra, rb));  // Each op consumes the one before
      issue(encode(cpu_pkg::op_sub, 4'd7, 4'd7, ra));
      issue(encode(cpu_pkg::op_and, 4'd7, 4'd7, rb));
      issue(encode(cpu_pkg::op_xor, 4'd7, 4'd7, ra));
      issue(encode(cpu_pkg::op_sll, 4'd7, 4'd7, rng[19:16]));
      issue(encode(cpu_pkg::op_sra, 4'd7, 4'd7, rng[23:20]));
    end
    drain();
    report_test("alu_ops", start_errs);
  endtask

  task automatic test_flags();
    int start_errs;
    start_errs = errors;
    issue(encode(cpu_pkg::op_addi, 4'd1, 4'd0, 4'd7));
    issue(encode(cpu_pkg::op_sll, 4'd1, 4'd1, 4'd12));  // 0x7000
    issue(encode(cpu_pkg::op_add, 4'd2, 4'd1, 4'd1));   // Positive overflow sets N and V
    issue(encode(cpu_pkg::op_xor, 4'd3, 4'd2, 4'd2));   // Zero result while N and V hold
    issue(encode(cpu_pkg::op_and, 4'd3, 4'd2, 4'd1));
    issue(encode(cpu_pkg::op_sub, 4'd4, 4'd2, 4'd2));   // Subtract to zero
    drain();
    report_test("flags", start_errs);
  endtask

  task automatic test_store_pcs();
    int start_errs;
    start_errs = errors;
    rng = xorshift(rng);
    issue(encode(cpu_pkg::op_addi, 4'd1, 4'd0, 4'd5));
    issue(encode(cpu_pkg::op_addi, 4'd2, 4'd0, 4'hd));
    issue(encode(cpu_pkg::op_sw, 4'd2, 4'd1, rng[3:0]));
    pc = rng[31:16];
    issue(encode(cpu_pkg::op_pcs, 4'd3, 4'd0, 4'd0));
    issue(encode(cpu_pkg::op_sw, 4'd3, 4'd2, rng[7:4]));  // Store data comes through bypass
    issue(encode(cpu_pkg::op_add, 4'd4, 4'd3, 4'd1));
    drain();
    report_test("store_pcs", start_errs);
  endtask

  task automatic test_bubble_flush();
    int start_errs;
    start_errs = errors;
    step(1'b0, 1'b0, encode(cpu_pkg::op_addi, 4'd3, 4'd0, 4'd5));  // Valid low
    step(1'b1, 1'b1, encode(cpu_pkg::op_addi, 4'd1, 4'd0, 4'd3));  // Squashed in ID/EX
    issue(encode(cpu_pkg::op_add, 4'd2, 4'd1, 4'd1));
    step(1'b1, 1'b1, encode(cpu_pkg::op_sw, 4'd2, 4'd1, 4'd0));
    issue(encode(cpu_pkg::op_sub, 4'd5, 4'd2, 4'd1));
    drain();
    report_test("bubble_flush", start_errs);
  endtask

  task automatic test_reg0();
    int start_errs;
    start_errs = errors;
    issue(encode(cpu_pkg::op_addi, 4'd0, 4'd0, 4'd5));
    issue(encode(cpu_pkg::op_add, 4'd1, 4'd0, 4'd0));  // Pending write to r0 must not bypass
    issue(encode(cpu_pkg::op_sw, 4'd0, 4'd1, 4'd2));
    drain();
    report_test("reg0", start_errs);
  endtask

  task automatic test_halt();
    int start_errs;
    int n;
    start_errs = errors;
    n = 0;
    issue(encode(cpu_pkg::op_addi, 4'd1, 4'd0, 4'd2));
    issue(encode(cpu_pkg::op_hlt, 4'd0, 4'd0, 4'd0));
    while (!halted && n < 6) begin
      step(1'b0, 1'b0, '0);
      n++;
    end
    if (!halted) begin
      errors++;
      $display("Timeout: halted did not rise within 6 cycles of the halt instruction");
    end
    issue(encode(cpu_pkg::op_addi, 4'd2, 4'd0, 4'd4));
    issue(encode(cpu_pkg::op_sw, 4'd1, 4'd1, 4'd1));
    drain();
    apply_reset();
    issue(encode(cpu_pkg::op_addi, 4'd1, 4'd0, 4'd1));  // Core runs again after reset
    drain();
    report_test("halt", start_errs);
  endtask

  initial begin
    clk = 1'b0;
    reset = 1'b1;
    flush = 1'b0;
    instr_valid = 1'b0;
    instr = '0;
    pc_next = '0;
    rng = 32'h6d72cafa;
    pc = 16'h0100;
    checks = 0;
    errors = 0;
    apply_reset();
    test_alu_ops();
    test_flags();
    test_store_pcs();
    test_bubble_flush();
    test_reg0();
    test_halt();
    errors = errors + dut0.props0.fail_count;
    $display("checks %0d, failures %0d", checks, errors);
    if (errors == 0) $display("No errors");
    else $display("Errors found");
    $finish;
  end

endmodule

`default_nettype wire
